// ==== hw/nn_pkg.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// perceptron shared definitions
// sizes, widths, weight memory layout, activation and update arithmetic
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package nn_pkg;

	// network shape
	localparam int N_IN = 4;
	localparam int N_HID = 6;
	localparam int N_OUT = 2;

	// datapath widths
	localparam int W_W = 8;
	localparam int X_W = 9;
	localparam int ACC_W = 20;
	localparam int DELTA_W = 13;
	localparam int UPD_W = X_W + DELTA_W;
	localparam int LR_SHIFT = 3;

	// one memory word holds a full row of weights
	localparam int N_SLOT = 24;
	localparam int ROW_W = N_SLOT * W_W;
	localparam int N_ROWS = 2;
	localparam logic ROW_L1 = 1'b0;
	localparam logic ROW_L2 = 1'b1;

	// slot dst*n_src+src holds the weight from src to dst
	function automatic logic signed [W_W-1:0] nn_slot(input logic [ROW_W-1:0] row, input int idx);
		return $signed(row[idx*W_W +: W_W]);
	endfunction

	// halve, then clamp to -1..+1
	function automatic logic signed [X_W-1:0] nn_activate(input logic signed [ACC_W-1:0] s);
		logic signed [ACC_W-1:0] half;
		half = s >>> 1;
		if (half > 1)
			return 1;
		else if (half < -1)
			return -1;
		return $signed(half[X_W-1:0]);
	endfunction

	// w - (h >>> LR_SHIFT) * e, wrapped to the weight width
	function automatic logic [W_W-1:0] nn_update_weight(input logic signed [W_W-1:0] w,
			input logic signed [X_W-1:0] h, input logic signed [DELTA_W-1:0] e);
		logic signed [UPD_W-1:0] step;
		logic signed [UPD_W-1:0] full;
		step = (h >>> LR_SHIFT) * e;
		full = w - step;
		return full[W_W-1:0];
	endfunction

endpackage

// ==== hw/nn_weight_ram.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// weight memory
// two rows, one full row per word, single port with registered read
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module nn_weight_ram (
	input  logic                     clk,
	input  logic                     reset,
	input  logic                     we,
	input  logic                     addr,
	input  logic [nn_pkg::ROW_W-1:0] wdata,
	output logic [nn_pkg::ROW_W-1:0] rdata
);
	import nn_pkg::*;

	logic [ROW_W-1:0] mem [N_ROWS];

	// read returns the old word when the same row is written
	always_ff @(posedge clk) begin
		if (we) begin
			mem[addr] <= wdata;
		end
		rdata <= mem[addr];
	end

	a_write_in_range: assert property (
		@(posedge clk) disable iff (reset)
		we |-> (int'(addr) < N_ROWS)
	);

endmodule

// ==== hw/nn_sequencer.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// run sequencer
// turns start, train and load into fixed phase strobes, owns the memory port
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module nn_sequencer (
	input  logic                     clk,
	input  logic                     reset,
	input  logic                     start,
	input  logic                     train,
	input  logic                     load,
	input  logic                     load_addr,
	input  logic [nn_pkg::ROW_W-1:0] load_row,
	input  logic [nn_pkg::ROW_W-1:0] upd_row,
	output logic                     we,
	output logic                     addr,
	output logic [nn_pkg::ROW_W-1:0] wdata,
	output logic                     l1_en,
	output logic                     l2_en,
	output logic                     cap_en,
	output logic                     upd_en,
	output logic                     finish,
	output logic                     busy
);
	import nn_pkg::*;

	typedef enum logic [2:0] {S_IDLE, S_L1, S_A2, S_L2, S_CAP, S_UPD, S_WR} state_t;

	state_t state;
	logic train_q;
	logic idle;
	logic load_go;

	assign idle = (state == S_IDLE);
	// start wins over a load in the same idle cycle
	assign load_go = idle && load && !start;

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= S_IDLE;
			train_q <= 1'b0;
		end else begin
			case (state)
				S_IDLE: begin
					if (start) begin
						state <= S_L1;
						train_q <= train;
					end
				end
				S_L1: state <= S_A2;
				S_A2: state <= S_L2;
				S_L2: state <= S_CAP;
				S_CAP: state <= train_q ? S_UPD : S_IDLE;
				S_UPD: state <= S_WR;
				S_WR: state <= S_IDLE;
				default: state <= S_IDLE;
			endcase
		end
	end

	// row 0 is presented while idle so the read is ready when start lands
	always_comb begin
		case (state)
			S_IDLE: addr = load_go ? load_addr : ROW_L1;
			S_L1: addr = ROW_L1;
			default: addr = ROW_L2;
		endcase
	end

	assign we = load_go || (state == S_WR);
	assign wdata = (state == S_WR) ? upd_row : load_row;

	assign l1_en = (state == S_L1);
	assign l2_en = (state == S_L2);
	assign cap_en = (state == S_CAP);
	assign upd_en = (state == S_UPD);
	// inference ends at capture, training after write-back
	assign finish = (cap_en && !train_q) || (state == S_WR);
	assign busy = !idle;

	a_finish_pulse: assert property (
		@(posedge clk) disable iff (reset)
		finish |=> !finish
	);

	a_no_write_in_compute: assert property (
		@(posedge clk) disable iff (reset)
		(l1_en || l2_en) |-> !we
	);

endmodule

// ==== hw/nn_layer.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// dense layer
// dot products of the sources over one weight row, optional saturation
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module nn_layer #(
	parameter int N_SRC = 4,
	parameter int N_DST = 6,
	parameter bit SATURATE = 1'b1
) (
	input  logic                             clk,
	input  logic                             reset,
	input  logic                             en,
	input  logic signed [nn_pkg::X_W-1:0]    src [N_SRC],
	input  logic [nn_pkg::ROW_W-1:0]         row,
	output logic signed [nn_pkg::ACC_W-1:0]  sum [N_DST],
	output logic signed [nn_pkg::X_W-1:0]    act [N_DST]
);
	import nn_pkg::*;

	logic signed [ACC_W-1:0] dot [N_DST];

	// accumulator is wide enough for every product, no overflow
	always_comb begin
		for (int d = 0; d < N_DST; d++) begin
			dot[d] = '0;
			for (int s = 0; s < N_SRC; s++) begin
				dot[d] = dot[d] + src[s] * nn_slot(row, d * N_SRC + s);
			end
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int d = 0; d < N_DST; d++) begin
				sum[d] <= '0;
			end
		end else if (en) begin
			for (int d = 0; d < N_DST; d++) begin
				sum[d] <= dot[d];
			end
		end
	end

	generate
		if (SATURATE) begin : g_sat
			always_ff @(posedge clk) begin
				if (reset) begin
					for (int d = 0; d < N_DST; d++) begin
						act[d] <= '0;
					end
				end else if (en) begin
					for (int d = 0; d < N_DST; d++) begin
						act[d] <= nn_activate(dot[d]);
					end
				end
			end
		end else begin : g_lin
			// linear layer, only sum carries data
			always_comb begin
				for (int d = 0; d < N_DST; d++) begin
					act[d] = '0;
				end
			end
		end
	endgenerate

endmodule

// ==== hw/nn_weight_update.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// output layer weight update
// new row = old row minus scaled hidden value times error, per weight
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module nn_weight_update (
	input  logic                              clk,
	input  logic                              reset,
	input  logic                              en,
	input  logic signed [nn_pkg::X_W-1:0]     hidden [nn_pkg::N_HID],
	input  logic signed [nn_pkg::DELTA_W-1:0] err [nn_pkg::N_OUT],
	input  logic [nn_pkg::ROW_W-1:0]          row,
	output logic [nn_pkg::ROW_W-1:0]          new_row
);
	import nn_pkg::*;

	logic [ROW_W-1:0] next_row;

	// upper slots are unused and pass through
	always_comb begin
		next_row = row;
		for (int j = 0; j < N_OUT; j++) begin
			for (int i = 0; i < N_HID; i++) begin
				next_row[(j*N_HID+i)*W_W +: W_W] =
					nn_update_weight(nn_slot(row, j * N_HID + i), hidden[i], err[j]);
			end
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			new_row <= '0;
		end else if (en) begin
			new_row <= next_row;
		end
	end

endmodule

// ==== hw/nn_output_stage.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// result stage
// holds network outputs and error terms, flags the end of a run
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module nn_output_stage (
	input  logic                              clk,
	input  logic                              reset,
	input  logic                              cap_en,
	input  logic                              upd_en,
	input  logic                              finish,
	input  logic signed [nn_pkg::ACC_W-1:0]   sum [nn_pkg::N_OUT],
	input  logic signed [nn_pkg::X_W-1:0]     desired [nn_pkg::N_OUT],
	output logic signed [nn_pkg::ACC_W-1:0]   y [nn_pkg::N_OUT],
	output logic signed [nn_pkg::DELTA_W-1:0] err [nn_pkg::N_OUT],
	output logic                              done
);
	import nn_pkg::*;

	logic signed [ACC_W-1:0] diff [N_OUT];

	always_comb begin
		for (int j = 0; j < N_OUT; j++) begin
			diff[j] = sum[j] - desired[j];
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int j = 0; j < N_OUT; j++) begin
				y[j] <= '0;
				err[j] <= '0;
			end
			done <= 1'b0;
		end else begin
			done <= finish;
			if (cap_en) begin
				for (int j = 0; j < N_OUT; j++) begin
					y[j] <= sum[j];
				end
				// finish together with capture means inference, errors kept
				if (!finish) begin
					for (int j = 0; j < N_OUT; j++) begin
						err[j] <= {diff[j][DELTA_W-2:0], 1'b0};
					end
				end
			end
		end
	end

	// fresh error terms must feed the update in the very next cycle
	a_err_then_update: assert property (
		@(posedge clk) disable iff (reset)
		(cap_en && !finish) |=> upd_en
	);

endmodule

// ==== hw/backprop_nn.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// trainable perceptron, 4 inputs, 6 hidden neurons, 2 outputs
// forward pass on start, output layer update when train is set
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module backprop_nn (
	input  logic                              clk,
	input  logic                              reset,
	input  logic                              start,
	input  logic                              train,
	input  logic signed [nn_pkg::X_W-1:0]     x0,
	input  logic signed [nn_pkg::X_W-1:0]     x1,
	input  logic signed [nn_pkg::X_W-1:0]     x2,
	input  logic signed [nn_pkg::X_W-1:0]     x3,
	input  logic signed [nn_pkg::X_W-1:0]     desired0,
	input  logic signed [nn_pkg::X_W-1:0]     desired1,
	input  logic                              load,
	input  logic                              load_addr,
	input  logic [nn_pkg::ROW_W-1:0]          load_row,
	output logic signed [nn_pkg::ACC_W-1:0]   y0,
	output logic signed [nn_pkg::ACC_W-1:0]   y1,
	output logic signed [nn_pkg::DELTA_W-1:0] err0,
	output logic signed [nn_pkg::DELTA_W-1:0] err1,
	output logic                              busy,
	output logic                              done
);
	import nn_pkg::*;

	logic we;
	logic addr;
	logic [ROW_W-1:0] wdata;
	logic [ROW_W-1:0] rdata;
	logic [ROW_W-1:0] upd_row;
	logic l1_en;
	logic l2_en;
	logic cap_en;
	logic upd_en;
	logic finish;
	logic signed [X_W-1:0] x_vec [N_IN];
	logic signed [X_W-1:0] desired_vec [N_OUT];
	logic signed [X_W-1:0] hidden [N_HID];
	logic signed [ACC_W-1:0] out_sum [N_OUT];
	logic signed [ACC_W-1:0] y_vec [N_OUT];
	logic signed [DELTA_W-1:0] err_vec [N_OUT];

	assign x_vec[0] = x0;
	assign x_vec[1] = x1;
	assign x_vec[2] = x2;
	assign x_vec[3] = x3;
	assign desired_vec[0] = desired0;
	assign desired_vec[1] = desired1;
	assign y0 = y_vec[0];
	assign y1 = y_vec[1];
	assign err0 = err_vec[0];
	assign err1 = err_vec[1];

	nn_sequencer i_sequencer (
		.clk, .reset, .start, .train, .load, .load_addr, .load_row,
		.upd_row, .we, .addr, .wdata, .l1_en, .l2_en, .cap_en, .upd_en,
		.finish, .busy
	);

	nn_weight_ram i_weight_ram (.clk, .reset, .we, .addr, .wdata, .rdata);

	// hidden layer, row 0
	nn_layer #(.N_SRC(N_IN), .N_DST(N_HID), .SATURATE(1'b1)) i_hidden_layer (
		.clk, .reset, .en(l1_en), .src(x_vec), .row(rdata), .sum(), .act(hidden)
	);

	// output layer, row 1
	nn_layer #(.N_SRC(N_HID), .N_DST(N_OUT), .SATURATE(1'b0)) i_output_layer (
		.clk, .reset, .en(l2_en), .src(hidden), .row(rdata), .sum(out_sum), .act()
	);

	nn_weight_update i_weight_update (
		.clk, .reset, .en(upd_en), .hidden, .err(err_vec), .row(rdata), .new_row(upd_row)
	);

	nn_output_stage i_output_stage (
		.clk, .reset, .cap_en, .upd_en, .finish, .sum(out_sum), .desired(desired_vec),
		.y(y_vec), .err(err_vec), .done
	);

endmodule

// ==== verification/nn_ref_model.svh ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// perceptron reference model
// weight copies, forward pass, error terms and output layer update
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef NN_REF_MODEL_SVH
`define NN_REF_MODEL_SVH

int ref_w [N_ROWS][N_SLOT];
int ref_x [N_IN];
int ref_d [N_OUT];
int ref_hid [N_HID];
int ref_y [N_OUT];
int ref_err [N_OUT];
// how often clamping and weight wrap were hit
int sat_hi_count;
int sat_lo_count;
int wrap_count;

// two's complement wrap of v into a signed field
function automatic int wrap_signed(input int v, input int bits);
	int m;
	m = v & ((1 << bits) - 1);
	if (m >= (1 << (bits - 1))) begin
		m = m - (1 << bits);
	end
	return m;
endfunction

function automatic void ref_load(input int row_addr, input logic [ROW_W-1:0] row);
	for (int s = 0; s < N_SLOT; s++) begin
		ref_w[row_addr][s] = wrap_signed(int'(row[s*W_W +: W_W]), W_W);
	end
endfunction

// halve, then clamp to -1..+1
function automatic int ref_activate(input int s);
	int half;
	half = s >>> 1;
	if (half > 1) begin
		sat_hi_count++;
		half = 1;
	end else if (half < -1) begin
		sat_lo_count++;
		half = -1;
	end
	return half;
endfunction

function automatic void ref_forward();
	int acc;
	for (int k = 0; k < N_HID; k++) begin
		acc = 0;
		for (int i = 0; i < N_IN; i++) begin
			acc += ref_x[i] * ref_w[0][k*N_IN + i];
		end
		ref_hid[k] = ref_activate(acc);
	end
	for (int j = 0; j < N_OUT; j++) begin
		acc = 0;
		for (int i = 0; i < N_HID; i++) begin
			acc += ref_hid[i] * ref_w[1][j*N_HID + i];
		end
		ref_y[j] = acc;
	end
endfunction

// error is twice (y - desired), row 1 then steps against it
function automatic void ref_train();
	int full;
	for (int j = 0; j < N_OUT; j++) begin
		ref_err[j] = wrap_signed(2 * (ref_y[j] - ref_d[j]), DELTA_W);
		for (int i = 0; i < N_HID; i++) begin
			full = ref_w[1][j*N_HID + i] - (ref_hid[i] >>> LR_SHIFT) * ref_err[j];
			if (full != wrap_signed(full, W_W)) begin
				wrap_count++;
			end
			ref_w[1][j*N_HID + i] = wrap_signed(full, W_W);
		end
	end
endfunction

`endif

// ==== verification/backprop_nn_tb.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// perceptron testbench
// random weight loads, inference and training runs checked against a model
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module backprop_nn_tb;
	import nn_pkg::*;

	// about 200 runs of at most 9 cycles each, plus margin
	localparam int TIMEOUT_CYCLES = 4000;
	localparam int RUN_LIMIT = 20;
	localparam int MIX_OPS = 200;

	logic clk;
	logic reset;
	logic start;
	logic train;
	logic signed [X_W-1:0] x0, x1, x2, x3;
	logic signed [X_W-1:0] desired0, desired1;
	logic load;
	logic load_addr;
	logic [ROW_W-1:0] load_row;
	logic signed [ACC_W-1:0] y0, y1;
	logic signed [DELTA_W-1:0] err0, err1;
	logic busy;
	logic done;

	int error_count;
	int check_count;
	int base_errors;
	int base_checks;
	int cycle_count;

	`include "nn_ref_model.svh"

	backprop_nn i_backprop_nn (
		.clk, .reset, .start, .train, .x0, .x1, .x2, .x3, .desired0, .desired1,
		.load, .load_addr, .load_row, .y0, .y1, .err0, .err1, .busy, .done
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	initial begin
		while (cycle_count < TIMEOUT_CYCLES) begin
			@(posedge clk);
			cycle_count++;
		end
		$display("timeout after %0d cycles, the tests did not finish", TIMEOUT_CYCLES);
		$display("Done: errors found");
		$finish;
	end

	task automatic check_value(input string name, input int got, input int expected);
		check_count++;
		assert (got == expected) else begin
			$display("ERROR at %0t: %s got %0d expected %0d", $time, name, got, expected);
			error_count++;
		end
	endtask

	task automatic check_true(input bit cond, input string what);
		check_count++;
		assert (cond) else begin
			$display("FAIL at %0t: %s", $time, what);
			error_count++;
		end
	endtask

	function automatic int rand_signed(input int bits);
		return int'($urandom_range(0, (1 << bits) - 1)) - (1 << (bits - 1));
	endfunction

	function automatic logic [ROW_W-1:0] random_row();
		logic [ROW_W-1:0] r;
		logic [31:0] v;
		for (int s = 0; s < N_SLOT; s++) begin
			v = $urandom;
			r[s*W_W +: W_W] = v[W_W-1:0];
		end
		return r;
	endfunction

	task automatic load_weights(input int row_addr, input logic [ROW_W-1:0] row);
		@(posedge clk);
		load <= 1'b1;
		load_addr <= row_addr[0];
		load_row <= row;
		@(posedge clk);
		load <= 1'b0;
		ref_load(row_addr, row);
	endtask

	// one run; with poke set a start and a load arrive mid run
	task automatic run_network(input bit do_train, input bit poke);
		int cycles;
		bit got_done;
		@(posedge clk);
		for (int i = 0; i < N_IN; i++) begin
			ref_x[i] = rand_signed(X_W);
		end
		for (int j = 0; j < N_OUT; j++) begin
			ref_d[j] = rand_signed(X_W);
		end
		x0 <= ref_x[0][X_W-1:0];
		x1 <= ref_x[1][X_W-1:0];
		x2 <= ref_x[2][X_W-1:0];
		x3 <= ref_x[3][X_W-1:0];
		desired0 <= ref_d[0][X_W-1:0];
		desired1 <= ref_d[1][X_W-1:0];
		train <= do_train;
		start <= 1'b1;
		cycles = 0;
		got_done = 1'b0;
		while (!got_done && cycles < RUN_LIMIT) begin
			@(posedge clk);
			cycles++;
			if (cycles == 1 || (poke && cycles == 3)) begin
				start <= 1'b0;
				load <= 1'b0;
			end else if (poke && cycles == 2) begin
				start <= 1'b1;
				load <= 1'b1;
				load_addr <= ROW_L2;
				load_row <= random_row();
			end
			@(negedge clk);
			got_done = done;
			check_true(!(busy && done), "busy and done high in the same cycle");
			if (!got_done) begin
				check_true(busy, "busy low while the run is still going");
			end
		end
		check_true(got_done, "done never arrived");
		check_value("done latency", cycles, do_train ? 7 : 5);
		ref_forward();
		if (do_train) begin
			ref_train();
		end
		check_value("y0", int'(y0), ref_y[0]);
		check_value("y1", int'(y1), ref_y[1]);
		check_value("err0", int'(err0), ref_err[0]);
		check_value("err1", int'(err1), ref_err[1]);
		@(negedge clk);
		check_true(!done, "done stayed high for more than one cycle");
		check_true(!busy, "a new run started without a start while idle");
	endtask

	task automatic begin_test();
		base_errors = error_count;
		base_checks = check_count;
	endtask

	task automatic end_test(input string name);
		int errs;
		errs = error_count - base_errors;
		if (errs == 0) begin
			$display("test %s: passed, %0d checks", name, check_count - base_checks);
		end else begin
			$display("test %s: failed, %0d wrong checks", name, errs);
		end
	endtask

	initial begin
		void'($urandom(32'h4cf4));
		reset = 1'b1;
		start = 1'b0;
		train = 1'b0;
		x0 = '0;
		x1 = '0;
		x2 = '0;
		x3 = '0;
		desired0 = '0;
		desired1 = '0;
		load = 1'b0;
		load_addr = 1'b0;
		load_row = '0;
		repeat (3) @(posedge clk);
		reset <= 1'b0;

		begin_test();
		@(negedge clk);
		check_value("busy", int'(busy), 0);
		check_value("done", int'(done), 0);
		check_value("y0", int'(y0), 0);
		check_value("y1", int'(y1), 0);
		check_value("err0", int'(err0), 0);
		check_value("err1", int'(err1), 0);
		end_test("reset");

		begin_test();
		load_weights(0, random_row());
		load_weights(1, random_row());
		run_network(1'b0, 1'b0);
		end_test("inference");

		// the second run sees the row written back by training
		begin_test();
		run_network(1'b1, 1'b0);
		run_network(1'b0, 1'b0);
		end_test("training");

		begin_test();
		run_network(1'b0, 1'b1);
		run_network(1'b1, 1'b1);
		run_network(1'b0, 1'b0);
		end_test("ignored requests");

		begin_test();
		sat_hi_count = 0;
		sat_lo_count = 0;
		wrap_count = 0;
		for (int n = 0; n < MIX_OPS; n++) begin
			case ($urandom_range(0, 2))
				0: load_weights(int'($urandom_range(0, 1)), random_row());
				1: run_network(1'b0, 1'b0);
				default: run_network(1'b1, 1'b0);
			endcase
		end
		check_true(sat_hi_count > 0, "no hidden value was clamped at +1");
		check_true(sat_lo_count > 0, "no hidden value was clamped at -1");
		check_true(wrap_count > 0, "no updated weight wrapped around");
		end_test("random mix");

		$display("tests: 5, checks: %0d, errors: %0d", check_count, error_count);
		if (error_count == 0) begin
			$display("Done: no errors");
		end else begin
			$display("Done: errors found");
		end
		$finish;
	end

endmodule

// ==== backprop_nn.f ====
+incdir+verification
hw/nn_pkg.sv
hw/nn_weight_ram.sv
hw/nn_sequencer.sv
hw/nn_layer.sv
hw/nn_weight_update.sv
hw/nn_output_stage.sv
hw/backprop_nn.sv
verification/backprop_nn_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the perceptron testbench with Verilator, run it, then scan the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module backprop_nn_tb \
	-f backprop_nn.f -Mdir obj_dir -o sim_backprop_nn

if ! ./obj_dir/sim_backprop_nn > sim.log 2>&1; then
	cat sim.log
	echo "simulator exited with an error"
	exit 1
fi
cat sim.log
if grep -q "Done: errors found" sim.log; then
	exit 1
fi
